//--- mcu_bridge.f
+incdir+.
mcu_proto_pkg.sv
mcu_mem_pkg.sv
mcu_cmd_fsm.sv
mcu_transfer_counter.sv
mcu_word_pack.sv
mcu_reg_file.sv
mcu_mem_dma.sv
mcu_top.sv
tb_mcu_top.sv

//--- mcu_cmd_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module mcu_cmd_fsm (
    input wire logic clk,
    input wire logic reset,
    input wire mcu_proto_pkg::rx_byte_t rx,
    output mcu_proto_pkg::cmd_e cmd,
    input wire logic [1:0] lane,
    output mcu_proto_pkg::access_t access,
    output logic addr_load
);

    import mcu_proto_pkg::*;

    phase_e phase;
    phase_e cur_phase;
    logic last_lane;

    // a frame start wins over whatever phase the last frame left behind
    assign cur_phase = rx.frame_start ? PHASE_CMD : phase;

    assign addr_load = rx.valid && (cur_phase == PHASE_ADDRESS);

    // registers use all four lanes, the buffer only the low lane bit
    assign last_lane = ((cmd == CMD_REG_READ) || (cmd == CMD_REG_WRITE)) ?
                       (lane == 2'd3) : lane[0];

    always_ff @(posedge clk) begin
        access <= '0;

        if (reset) begin
            phase <= PHASE_NOP;
            cmd <= CMD_IDENTIFY;
        end else if (rx.valid) begin
            case (cur_phase)
                PHASE_CMD: begin
                    cmd <= cmd_e'(rx.data);
                    phase <= (rx.data <= CMD_MEM_WRITE) ? PHASE_ADDRESS : PHASE_NOP;
                end

                PHASE_ADDRESS: begin
                    // first word of a read is fetched before any data slot
                    phase <= PHASE_DATA;
                    access.reg_read <= (cmd == CMD_REG_READ);
                    access.buf_read <= (cmd == CMD_MEM_READ);
                end

                PHASE_DATA: begin
                    if (last_lane) begin
                        access.reg_read <= (cmd == CMD_REG_READ);
                        access.reg_write <= (cmd == CMD_REG_WRITE);
                        access.buf_read <= (cmd == CMD_MEM_READ);
                        access.buf_write <= (cmd == CMD_MEM_WRITE);
                    end
                end

                default: begin
                end
            endcase
        end
    end

    // strobes are exclusive and last one clock, the byte gap keeps them apart
    assert property (@(posedge clk) disable iff (reset)
        (access != '0) |-> $onehot0(access) ##1 (access == '0));

endmodule

`default_nettype wire

//--- mcu_mem_dma.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcu_settings.svh"

module mcu_mem_dma (
    input wire logic clk,
    input wire logic reset,
    input wire mcu_proto_pkg::access_t access,
    input wire logic [`MCU_BUF_AW-1:0] buf_ptr,
    input wire logic [`MCU_MEM_W-1:0] buf_wdata,
    output logic [`MCU_MEM_W-1:0] buf_rdata,
    input wire mcu_mem_pkg::dma_ctrl_t dma,
    output logic busy,
    output mcu_mem_pkg::mem_req_t mem_req,
    input wire mcu_mem_pkg::mem_rsp_t mem_rsp
);

    logic [`MCU_MEM_W-1:0] buffer [`MCU_BUF_DEPTH];

    logic stop_pending;
    logic req;
    logic req_write;
    logic [31:0] req_addr;
    logic [`MCU_MEM_W-1:0] req_wdata;
    logic [`MCU_BUF_AW-1:0] count;
    logic [`MCU_BUF_AW-1:0] last;
    logic word_done;

    assign word_done = req && mem_rsp.ack;

    assign mem_req = '{request: req, write: req_write, address: req_addr, wdata: req_wdata};

    // byte engine port and DMA port share the one buffer
    always_ff @(posedge clk) begin
        if (access.buf_write) begin
            buffer[buf_ptr] <= buf_wdata;
        end
        if (access.buf_read) begin
            buf_rdata <= buffer[buf_ptr];
        end
        if (busy && word_done && !req_write) begin
            buffer[count] <= mem_rsp.rdata;
        end
        // fetch the outgoing word in the clock the request goes up
        if (busy && !req) begin
            req_wdata <= buffer[count];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            stop_pending <= 1'b0;
            req <= 1'b0;
        end else begin
            if (dma.stop) begin
                stop_pending <= busy;
            end else if (dma.start && !busy) begin
                busy <= 1'b1;
                req_write <= dma.direction;
                req_addr <= dma.address;
                count <= '0;
                last <= dma.length[`MCU_BUF_AW-1:0];
            end

            if (busy) begin
                if (!req) begin
                    req <= 1'b1;
                end
                if (word_done) begin
                    req <= 1'b0;
                    req_addr <= req_addr + 32'd2;
                    count <= count + 1'b1;
                    // a stop only takes effect once the word in flight is acked
                    if ((count == last) || stop_pending) begin
                        busy <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (mem_req.request && !mem_rsp.ack) |=> mem_req.request &&
        $stable({mem_req.write, mem_req.address, mem_req.wdata}));

endmodule

`default_nettype wire

//--- mcu_mem_pkg.sv
`default_nettype none

`include "mcu_settings.svh"

package mcu_mem_pkg;

    typedef enum logic [7:0] {
        REG_MEM_ADDRESS = 8'd0,
        REG_MEM_SCR     = 8'd1,
        REG_STATUS      = 8'd2
    } reg_addr_e;

    // start and stop only act on write, busy only shows on read
    typedef struct packed {
        logic [16:0]          reserved_hi;
        logic [`MCU_BUF_AW:0] length;
        logic                 reserved_lo;
        logic                 busy;
        logic                 direction;
        logic                 stop;
        logic                 start;
    } mem_scr_t;

    // length here is already the word count minus one
    typedef struct packed {
        logic                 start;
        logic                 stop;
        logic                 direction;
        logic [`MCU_BUF_AW:0] length;
        logic [31:0]          address;
    } dma_ctrl_t;

    typedef struct packed {
        logic                  request;
        logic                  write;
        logic [31:0]           address;
        logic [`MCU_MEM_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  ack;
        logic [`MCU_MEM_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- mcu_proto_pkg.sv
`default_nettype none

package mcu_proto_pkg;

    // unknown codes park the frame in the nop phase
    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } cmd_e;

    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA,
        PHASE_NOP
    } phase_e;

    typedef struct packed {
        logic       frame_start;
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

    // each field is a single clock pulse
    typedef struct packed {
        logic reg_read;
        logic reg_write;
        logic buf_read;
        logic buf_write;
    } access_t;

endpackage

`default_nettype wire

//--- mcu_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcu_settings.svh"

module mcu_reg_file (
    input wire logic clk,
    input wire logic reset,
    input wire mcu_mem_pkg::reg_addr_e reg_addr,
    input wire mcu_proto_pkg::access_t access,
    input wire logic [`MCU_REG_W-1:0] wdata,
    output logic [`MCU_REG_W-1:0] rdata,
    input wire logic dma_busy,
    output mcu_mem_pkg::dma_ctrl_t dma,
    input wire logic button,
    input wire logic sd_det
);

    import mcu_mem_pkg::*;

    localparam int REG_W = `MCU_REG_W;

    logic [2:0] button_ff;
    logic [2:0] sd_det_ff;
    mem_scr_t scr_wr;
    mem_scr_t scr_rd;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[1:0], button};
        sd_det_ff <= {sd_det_ff[1:0], sd_det};
    end

    assign scr_wr = mem_scr_t'(wdata);

    always_comb begin
        scr_rd = '0;
        scr_rd.busy = dma_busy;
        scr_rd.direction = dma.direction;
    end

    always_ff @(posedge clk) begin
        if (access.reg_read) begin
            case (reg_addr)
                REG_MEM_ADDRESS: rdata <= dma.address;
                REG_MEM_SCR: rdata <= scr_rd;
                // both inputs are low when active
                REG_STATUS: rdata <= REG_W'({~button_ff[2], ~sd_det_ff[2]});
                default: rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dma.start <= 1'b0;
        dma.stop <= 1'b0;

        if (reset) begin
            dma.direction <= 1'b0;
            dma.length <= '0;
            dma.address <= '0;
        end else if (access.reg_write) begin
            case (reg_addr)
                REG_MEM_ADDRESS: dma.address <= wdata;
                REG_MEM_SCR: begin
                    dma.start <= scr_wr.start;
                    dma.stop <= scr_wr.stop;
                    dma.direction <= scr_wr.direction;
                    dma.length <= scr_wr.length - 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mcu_settings.svh
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// reply byte for the identify command
`define MCU_FPGA_ID 8'h64

// transfer buffer shared by the byte engine and the DMA
`define MCU_BUF_DEPTH 512
`define MCU_BUF_AW 9

// register words travel least significant byte first
`define MCU_REG_W 32

// buffer and memory bus words travel most significant byte first
`define MCU_MEM_W 16

// the transport never delivers two bytes closer than this many clocks
// tx_data has to be settled one clock before the next byte slot
`define MCU_MIN_GAP 4

`endif

//--- mcu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcu_settings.svh"

module mcu_top (
    input wire logic clk,
    input wire logic reset,
    input wire mcu_proto_pkg::rx_byte_t rx,
    output logic [7:0] tx_data,
    output mcu_mem_pkg::mem_req_t mem_req,
    input wire mcu_mem_pkg::mem_rsp_t mem_rsp,
    input wire logic button,
    input wire logic sd_det
);

    import mcu_proto_pkg::*;
    import mcu_mem_pkg::*;

    cmd_e cmd;
    logic [1:0] lane;
    access_t access;
    logic addr_load;
    reg_addr_e reg_addr;
    logic [`MCU_BUF_AW-1:0] buf_ptr;
    logic [`MCU_REG_W-1:0] reg_wword;
    logic [`MCU_REG_W-1:0] reg_rword;
    logic [7:0] reg_tx;
    logic [`MCU_MEM_W-1:0] buf_wword;
    logic [`MCU_MEM_W-1:0] buf_rword;
    logic [7:0] buf_tx;
    logic reg_capture;
    logic buf_capture;
    dma_ctrl_t dma;
    logic dma_busy;

    // write data bytes only, the address byte sits in lane 0 as well
    assign reg_capture = rx.valid && !rx.frame_start && !addr_load && (cmd == CMD_REG_WRITE);
    assign buf_capture = rx.valid && !rx.frame_start && !addr_load && (cmd == CMD_MEM_WRITE);

    mcu_cmd_fsm cmd_fsm (
        .clk(clk), .reset(reset), .rx(rx), .cmd(cmd), .lane(lane),
        .access(access), .addr_load(addr_load)
    );

    mcu_transfer_counter transfer_counter (
        .clk(clk), .reset(reset), .rx(rx), .addr_load(addr_load), .access(access),
        .lane(lane), .reg_addr(reg_addr), .buf_ptr(buf_ptr)
    );

    mcu_word_pack #(.word_t(logic [`MCU_REG_W-1:0]), .MSB_FIRST(1'b0)) reg_pack (
        .clk(clk), .rx(rx), .lane(lane), .capture(reg_capture),
        .wword(reg_wword), .rword(reg_rword), .tx_byte(reg_tx)
    );

    mcu_word_pack #(.word_t(logic [`MCU_MEM_W-1:0]), .MSB_FIRST(1'b1)) buf_pack (
        .clk(clk), .rx(rx), .lane(lane), .capture(buf_capture),
        .wword(buf_wword), .rword(buf_rword), .tx_byte(buf_tx)
    );

    mcu_reg_file reg_file (
        .clk(clk), .reset(reset), .reg_addr(reg_addr), .access(access), .wdata(reg_wword),
        .rdata(reg_rword), .dma_busy(dma_busy), .dma(dma), .button(button), .sd_det(sd_det)
    );

    mcu_mem_dma mem_dma (
        .clk(clk), .reset(reset), .access(access), .buf_ptr(buf_ptr), .buf_wdata(buf_wword),
        .buf_rdata(buf_rword), .dma(dma), .busy(dma_busy), .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    always_comb begin
        case (cmd)
            CMD_IDENTIFY: tx_data = `MCU_FPGA_ID;
            CMD_REG_READ: tx_data = reg_tx;
            CMD_MEM_READ: tx_data = buf_tx;
            default: tx_data = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- mcu_transfer_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcu_settings.svh"

module mcu_transfer_counter (
    input wire logic clk,
    input wire logic reset,
    input wire mcu_proto_pkg::rx_byte_t rx,
    input wire logic addr_load,
    input wire mcu_proto_pkg::access_t access,
    output logic [1:0] lane,
    output mcu_mem_pkg::reg_addr_e reg_addr,
    output logic [`MCU_BUF_AW-1:0] buf_ptr
);

    import mcu_mem_pkg::*;

    logic in_data;

    // lanes only count once the address byte has gone by
    always_ff @(posedge clk) begin
        if (reset || (rx.valid && rx.frame_start)) begin
            lane <= 2'd0;
            in_data <= 1'b0;
        end else if (addr_load) begin
            lane <= 2'd0;
            in_data <= 1'b1;
        end else if (rx.valid && in_data) begin
            lane <= lane + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_addr <= REG_MEM_ADDRESS;
            buf_ptr <= '0;
        end else if (addr_load) begin
            // the address byte selects a pair of buffer words
            reg_addr <= reg_addr_e'(rx.data);
            buf_ptr <= {rx.data, 1'b0};
        end else begin
            if (access.reg_read || access.reg_write) begin
                reg_addr <= reg_addr_e'(reg_addr + 8'd1);
            end
            if (access.buf_read || access.buf_write) begin
                buf_ptr <= buf_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- mcu_word_pack.sv
`timescale 1ns/100ps
`default_nettype none

module mcu_word_pack #(
    parameter type word_t = logic [31:0],
    parameter bit MSB_FIRST = 1'b0
) (
    input wire logic clk,
    input wire mcu_proto_pkg::rx_byte_t rx,
    input wire logic [1:0] lane,
    input wire logic capture,
    output word_t wword,
    input wire word_t rword,
    output logic [7:0] tx_byte
);

    localparam int NBYTES = $bits(word_t) / 8;
    localparam int LW = $clog2(NBYTES);

    logic [LW-1:0] idx;

    // byte position inside the word for the current lane
    always_comb begin
        if (MSB_FIRST) begin
            idx = LW'(NBYTES - 1) - lane[LW-1:0];
        end else begin
            idx = lane[LW-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            wword[idx*8 +: 8] <= rx.data;
        end
    end

    assign tx_byte = rword[idx*8 +: 8];

endmodule

`default_nettype wire

//--- tb_mcu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mcu_settings.svh"

module tb_mcu_top;

    import mcu_proto_pkg::*;
    import mcu_mem_pkg::*;

    localparam int GAP = `MCU_MIN_GAP;
    localparam int DEPTH = `MCU_BUF_DEPTH;
    localparam int REG_W = `MCU_REG_W;

    logic clk = 1'b0;
    logic reset;
    rx_byte_t rx;
    logic [7:0] tx_data;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic button;
    logic sd_det;

    // reference copies of the DUT buffer and of the external memory
    logic [`MCU_MEM_W-1:0] buf_model [DEPTH];
    logic [`MCU_MEM_W-1:0] mem_model [logic [31:0]];

    logic [`MCU_REG_W-1:0] reg_words [8];
    logic [`MCU_MEM_W-1:0] buf_words [DEPTH];

    // the memory slave predicts each DMA word from these
    int dma_idx;
    logic [31:0] dma_base;
    logic dma_dir;
    int ack_delay = -1;

    mcu_top uut (
        .clk(clk), .reset(reset), .rx(rx), .tx_data(tx_data),
        .mem_req(mem_req), .mem_rsp(mem_rsp), .button(button), .sd_det(sd_det)
    );

    always #50 clk = ~clk;

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not finish in time", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic check_reg(input string name, input logic [`MCU_REG_W-1:0] exp,
                             input logic [`MCU_REG_W-1:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // wdata only matters when the DMA writes to memory
    task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t act);
        if ((act.request !== exp.request) || (act.write !== exp.write) ||
            (act.address !== exp.address) || (exp.write && (act.wdata !== exp.wdata))) begin
            $display("[FAIL] %s expected w=%b a=%h d=%h actual w=%b a=%h d=%h",
                     name, exp.write, exp.address, exp.wdata,
                     act.write, act.address, act.wdata);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // tx_data is sampled in the slot that carries the new byte
    task automatic send_byte(input logic start, input logic [7:0] data, output logic [7:0] tx);
        tx = tx_data;
        rx = '{frame_start: start, valid: 1'b1, data: data};
        @(negedge clk);
        rx = '0;
        repeat (GAP - 1) @(negedge clk);
    endtask

    task automatic write_regs(input logic [7:0] addr, input int n);
        logic [7:0] tx;
        send_byte(1'b1, CMD_REG_WRITE, tx);
        send_byte(1'b0, addr, tx);
        for (int i = 0; i < n; i++) begin
            for (int l = 0; l < 4; l++) begin
                send_byte(1'b0, reg_words[i][8*l +: 8], tx);
            end
        end
    endtask

    task automatic read_regs(input logic [7:0] addr, input int n);
        logic [7:0] tx;
        send_byte(1'b1, CMD_REG_READ, tx);
        send_byte(1'b0, addr, tx);
        for (int i = 0; i < n; i++) begin
            for (int l = 0; l < 4; l++) begin
                send_byte(1'b0, 8'h00, tx);
                reg_words[i][8*l +: 8] = tx;
            end
        end
    endtask

    task automatic write_buffer(input logic [7:0] addr, input int n);
        logic [7:0] tx;
        send_byte(1'b1, CMD_MEM_WRITE, tx);
        send_byte(1'b0, addr, tx);
        for (int i = 0; i < n; i++) begin
            send_byte(1'b0, buf_words[i][15:8], tx);
            send_byte(1'b0, buf_words[i][7:0], tx);
        end
    endtask

    task automatic read_buffer(input logic [7:0] addr, input int n);
        logic [7:0] tx;
        send_byte(1'b1, CMD_MEM_READ, tx);
        send_byte(1'b0, addr, tx);
        for (int i = 0; i < n; i++) begin
            send_byte(1'b0, 8'h00, tx);
            buf_words[i][15:8] = tx;
            send_byte(1'b0, 8'h00, tx);
            buf_words[i][7:0] = tx;
        end
    endtask

    function automatic mem_scr_t make_scr(input logic start, input logic dir, input int len);
        mem_scr_t s;
        s = '0;
        s.start = start;
        s.direction = dir;
        s.length = len[`MCU_BUF_AW:0];
        return s;
    endfunction

    task automatic wait_dma_idle();
        mem_scr_t scr;
        bit idle;
        idle = 1'b0;
        for (int polls = 0; polls < 300 && !idle; polls++) begin
            read_regs(REG_MEM_SCR, 1);
            scr = mem_scr_t'(reg_words[0]);
            idle = !scr.busy;
        end
        if (!idle) begin
            abort_on_timeout("DMA busy poll");
        end
    endtask

    task automatic wait_bus_idle();
        for (int i = 0; i < 50 && mem_req.request; i++) begin
            @(negedge clk);
        end
        if (mem_req.request) begin
            abort_on_timeout("memory ack wait");
        end
    endtask

    task automatic run_dma(input logic [31:0] base, input logic dir, input int len);
        dma_idx = 0;
        dma_base = base;
        dma_dir = dir;
        reg_words[0] = base;
        reg_words[1] = make_scr(1'b1, dir, len);
        write_regs(REG_MEM_ADDRESS, 2);
        wait_dma_idle();
        wait_bus_idle();
        check_reg("dma word count", REG_W'(len), REG_W'(dma_idx));
    endtask

    // behavioral memory slave, acks each request after 0 to 5 clocks
    always @(negedge clk) begin : mem_slave
        mem_req_t exp;
        mem_rsp.ack = 1'b0;
        if (mem_req.request && !reset) begin
            if (ack_delay < 0) begin
                ack_delay = $urandom_range(5, 0);
            end
            if (ack_delay == 0) begin
                exp = '0;
                exp.request = 1'b1;
                exp.write = dma_dir;
                exp.address = dma_base + 32'(2 * dma_idx);
                exp.wdata = buf_model[dma_idx];
                check_mem("dma request", exp, mem_req);
                if (mem_req.write) begin
                    mem_model[mem_req.address] = mem_req.wdata;
                end else begin
                    mem_rsp.rdata = mem_model.exists(mem_req.address) ?
                                    mem_model[mem_req.address] : '0;
                    buf_model[dma_idx] = mem_rsp.rdata;
                end
                mem_rsp.ack = 1'b1;
                dma_idx++;
                ack_delay = -1;
            end else begin
                ack_delay--;
            end
        end
    end

    initial begin
        int len;
        int n;
        int idx;
        logic [7:0] addr_byte;
        logic [7:0] tx;
        logic [31:0] base;
        logic b_lvl;
        logic s_lvl;

        void'($urandom(32'hfb88));
        reset = 1'b1;
        rx = '0;
        mem_rsp = '0;
        button = 1'b1;
        sd_det = 1'b1;
        dma_idx = 0;
        dma_base = '0;
        dma_dir = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);

        // both words come back from one frame, so the address auto-increments
        reg_words[0] = $urandom;
        reg_words[1] = make_scr(1'b0, 1'b1, $urandom_range(512, 1));
        write_regs(REG_MEM_ADDRESS, 2);
        base = reg_words[0];
        read_regs(REG_MEM_ADDRESS, 2);
        check_reg("mem_address readback", base, reg_words[0]);
        check_reg("mem_scr readback", 32'h0000_0004, reg_words[1]);
        read_regs(8'd9, 1);
        check_reg("unmapped register", '0, reg_words[0]);

        // identify answers in every slot after the command byte
        send_byte(1'b1, CMD_IDENTIFY, tx);
        for (int i = 0; i < 5; i++) begin
            send_byte(1'b0, 8'($urandom), tx);
            check_byte("identify", 8'h64, tx);
        end

        for (int t = 0; t < 4; t++) begin
            addr_byte = 8'($urandom);
            n = $urandom_range(8, 1);
            for (int i = 0; i < n; i++) begin
                buf_words[i] = 16'($urandom);
                buf_model[(addr_byte * 2 + i) % DEPTH] = buf_words[i];
            end
            write_buffer(addr_byte, n);
            read_buffer(addr_byte, n);
            for (int i = 0; i < n; i++) begin
                idx = (addr_byte * 2 + i) % DEPTH;
                check_byte("buffer msb", buf_model[idx][15:8], buf_words[i][15:8]);
                check_byte("buffer lsb", buf_model[idx][7:0], buf_words[i][7:0]);
            end
        end

        // buffer to memory, the slave checks every word and address
        len = $urandom_range(64, 1);
        for (int i = 0; i < len; i++) begin
            buf_words[i] = 16'($urandom);
            buf_model[i] = buf_words[i];
        end
        write_buffer(8'd0, len);
        run_dma($urandom & 32'hffff_fffe, 1'b1, len);

        // memory to buffer from fresh random contents
        len = $urandom_range(64, 1);
        base = $urandom & 32'hffff_fffe;
        for (int i = 0; i < len; i++) begin
            mem_model[base + 32'(2 * i)] = 16'($urandom);
        end
        run_dma(base, 1'b0, len);
        read_buffer(8'd0, len);
        for (int i = 0; i < len; i++) begin
            check_byte("dma fill msb", mem_model[base + 32'(2 * i)][15:8], buf_words[i][15:8]);
            check_byte("dma fill lsb", mem_model[base + 32'(2 * i)][7:0], buf_words[i][7:0]);
        end

        for (int t = 0; t < 4; t++) begin
            b_lvl = 1'($urandom);
            s_lvl = 1'($urandom);
            button = b_lvl;
            sd_det = s_lvl;
            repeat (5) @(negedge clk);
            read_regs(REG_STATUS, 1);
            check_reg("status", REG_W'({~b_lvl, ~s_lvl}), reg_words[0]);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
